//--- Bender.yml
package:
  name: daq_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/daq_pkg.sv
      - rtl/bus_decoder.sv
      - rtl/system_regs.sv
      - rtl/board_gpio.sv
      - rtl/reset_pulser.sv
      - rtl/readout_arbiter.sv
      - rtl/daq_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_daq_core.sv

//--- flist.f
+incdir+include
rtl/daq_pkg.sv
rtl/bus_decoder.sv
rtl/system_regs.sv
rtl/board_gpio.sv
rtl/reset_pulser.sv
rtl/readout_arbiter.sv
rtl/daq_core.sv
tests/tb_daq_core.sv

//--- include/daq_config.svh
`ifndef DAQ_CONFIG_SVH
`define DAQ_CONFIG_SVH

// Local bus widths
`define DAQ_ABUS_WIDTH 32
`define DAQ_DBUS_WIDTH 8
// Offset width inside one register block
`define DAQ_LOCAL_ADD_WIDTH 8

// Readout stream
`define DAQ_WORD_WIDTH 32
`define DAQ_NUM_SOURCES 3

// Address map, one 256-byte window per block
`define DAQ_SYSTEM_BASEADDR 32'h0000_0300
`define DAQ_SYSTEM_HIGHADDR 32'h0000_03FF

// Chip reset pulser
`define DAQ_PULSE_RST_BASEADDR 32'h0000_0400
`define DAQ_PULSE_RST_HIGHADDR 32'h0000_04FF

// Board control GPIO
`define DAQ_GPIO_BASEADDR 32'h0000_0500
`define DAQ_GPIO_HIGHADDR 32'h0000_05FF

// Firmware identification bytes
`define DAQ_VERSION 8'd1
`define DAQ_VERSION_MINOR 8'd0
`define DAQ_VERSION_MAJOR 8'd2

// Board ID 0 is the simulation board
`define DAQ_BOARD_ID 8'd0

`endif

//--- rtl/board_gpio.sv
`timescale 1ns/1ps

module board_gpio (
    input  logic                  BUS_CLK,
    input  logic                  BUS_RST,
    input  daq_pkg::ip_req_t      i_req,
    output daq_pkg::bus_data_t    o_rdata,
    input  logic [3:0]            i_gpio_sense,
    output daq_pkg::board_ctrl_t  o_board_ctrl,
    output logic                  o_rst_hold
);

    // Register offsets
    localparam daq_pkg::local_addr_t ADD_HOLD  = 8'd0;
    localparam daq_pkg::local_addr_t ADD_LEMO  = 8'd1;
    localparam daq_pkg::local_addr_t ADD_MISC  = 8'd2;
    localparam daq_pkg::local_addr_t ADD_SENSE = 8'd3;

    // Control bits
    logic       rst_hold_q;
    logic [7:0] lemo_mux_q;
    logic [2:0] ntc_mux_q;
    // Stored as written, 0 selects the internal reference
    logic       mgt_sel_q;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rst_hold_q <= 1'b0;
            lemo_mux_q <= '0;
            ntc_mux_q  <= '0;
            mgt_sel_q  <= 1'b0;
        end else if (i_req.wr) begin
            case (i_req.add)
                ADD_HOLD: begin
                    rst_hold_q <= i_req.data[0];
                end
                ADD_LEMO: begin
                    lemo_mux_q <= i_req.data;
                end
                ADD_MISC: begin
                    ntc_mux_q <= i_req.data[2:0];
                    mgt_sel_q <= i_req.data[7];
                end
                // Sense byte is read-only
                default: begin
                end
            endcase
        end
    end

    // Readback of the control bytes and the sense lines
    always_ff @(posedge BUS_CLK) begin
        if (i_req.rd) begin
            case (i_req.add)
                ADD_HOLD:  o_rdata <= {7'b0, rst_hold_q};
                ADD_LEMO:  o_rdata <= lemo_mux_q;
                ADD_MISC:  o_rdata <= {mgt_sel_q, 4'b0, ntc_mux_q};
                ADD_SENSE: o_rdata <= {4'b0, i_gpio_sense};
                default:   o_rdata <= '0;
            endcase
        end
    end

    // MGT select leaves inverted
    assign o_board_ctrl = '{
        mgt_ref_sel: ~mgt_sel_q,
        lemo_mux:    lemo_mux_q,
        ntc_mux:     ntc_mux_q
    };

    assign o_rst_hold = rst_hold_q;

endmodule

//--- rtl/bus_decoder.sv
`timescale 1ns/1ps
`include "daq_config.svh"

module bus_decoder (
    input  logic                BUS_CLK,
    input  logic                BUS_RST,
    input  daq_pkg::bus_addr_t  i_bus_add,
    input  daq_pkg::bus_data_t  i_bus_data,
    input  logic                i_bus_rd,
    input  logic                i_bus_wr,
    output daq_pkg::ip_req_t    o_sys_req,
    output daq_pkg::ip_req_t    o_gpio_req,
    output daq_pkg::ip_req_t    o_pulse_req,
    input  daq_pkg::bus_data_t  i_sys_rdata,
    input  daq_pkg::bus_data_t  i_gpio_rdata,
    input  daq_pkg::bus_data_t  i_pulse_rdata,
    output daq_pkg::bus_data_t  o_bus_data
);

    // Registered read selector: bit 0 system, 1 gpio, 2 pulser
    logic [2:0] sel_q;

    // Build one block request from the shared bus
    function automatic daq_pkg::ip_req_t decode_req(
        input daq_pkg::bus_addr_t base,
        input daq_pkg::bus_addr_t high,
        input daq_pkg::bus_addr_t add,
        input logic               rd,
        input logic               wr,
        input daq_pkg::bus_data_t data
    );
        daq_pkg::ip_req_t   req;
        daq_pkg::bus_addr_t offset;
        logic               hit;
        hit      = (add >= base) && (add <= high);
        offset   = add - base;
        req.rd   = rd & hit;
        req.wr   = wr & hit;
        // Window is 256 bytes, upper offset bits are always zero on a hit
        req.add  = offset[`DAQ_LOCAL_ADD_WIDTH-1:0];
        req.data = data;
        return req;
    endfunction

    assign o_sys_req   = decode_req(`DAQ_SYSTEM_BASEADDR, `DAQ_SYSTEM_HIGHADDR,
                                    i_bus_add, i_bus_rd, i_bus_wr, i_bus_data);
    assign o_gpio_req  = decode_req(`DAQ_GPIO_BASEADDR, `DAQ_GPIO_HIGHADDR,
                                    i_bus_add, i_bus_rd, i_bus_wr, i_bus_data);
    assign o_pulse_req = decode_req(`DAQ_PULSE_RST_BASEADDR, `DAQ_PULSE_RST_HIGHADDR,
                                    i_bus_add, i_bus_rd, i_bus_wr, i_bus_data);

    // Remember which block answers the read, same edge as its data register
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            sel_q <= '0;
        end else begin
            sel_q <= {o_pulse_req.rd, o_gpio_req.rd, o_sys_req.rd};
        end
    end

    // Unmapped reads leave sel_q empty and return 0
    always_comb begin
        o_bus_data = '0;
        if (sel_q[0]) o_bus_data = i_sys_rdata;
        if (sel_q[1]) o_bus_data = i_gpio_rdata;
        if (sel_q[2]) o_bus_data = i_pulse_rdata;
    end

endmodule

//--- rtl/daq_core.sv
`timescale 1ns/1ps
`include "daq_config.svh"

module daq_core (
    input  logic                                       BUS_CLK,
    input  logic                                       BUS_RST,
    // Local bus
    input  daq_pkg::bus_addr_t                         i_bus_add,
    input  daq_pkg::bus_data_t                         i_bus_data,
    output daq_pkg::bus_data_t                         o_bus_data,
    input  logic                                       i_bus_rd,
    input  logic                                       i_bus_wr,
    // Board control
    input  logic [3:0]                                 i_gpio_sense,
    output daq_pkg::board_ctrl_t                       o_board_ctrl,
    output logic                                       o_resetb_ext,
    // Readout sources
    input  daq_pkg::src_mask_t                         i_src_empty,
    input  daq_pkg::src_mask_t                         i_src_hold,
    input  daq_pkg::arb_word_t [`DAQ_NUM_SOURCES-1:0]  i_src_data,
    output daq_pkg::src_mask_t                         o_src_read,
    // Merged output stream
    input  logic                                       i_arb_ready,
    output logic                                       o_arb_write,
    output daq_pkg::arb_word_t                         o_arb_data
);

    daq_pkg::ip_req_t   sys_req;
    daq_pkg::ip_req_t   gpio_req;
    daq_pkg::ip_req_t   pulse_req;
    daq_pkg::bus_data_t sys_rdata;
    daq_pkg::bus_data_t gpio_rdata;
    daq_pkg::bus_data_t pulse_rdata;
    // GPIO hold bit into the pulser
    logic               rst_hold;

    bus_decoder i_bus_decoder (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .i_bus_add    (i_bus_add),
        .i_bus_data   (i_bus_data),
        .i_bus_rd     (i_bus_rd),
        .i_bus_wr     (i_bus_wr),
        .o_sys_req    (sys_req),
        .o_gpio_req   (gpio_req),
        .o_pulse_req  (pulse_req),
        .i_sys_rdata  (sys_rdata),
        .i_gpio_rdata (gpio_rdata),
        .i_pulse_rdata(pulse_rdata),
        .o_bus_data   (o_bus_data)
    );

    system_regs i_system_regs (
        .BUS_CLK(BUS_CLK),
        .BUS_RST(BUS_RST),
        .i_req  (sys_req),
        .o_rdata(sys_rdata)
    );

    board_gpio i_board_gpio (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_req       (gpio_req),
        .o_rdata     (gpio_rdata),
        .i_gpio_sense(i_gpio_sense),
        .o_board_ctrl(o_board_ctrl),
        .o_rst_hold  (rst_hold)
    );

    reset_pulser i_reset_pulser (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_req       (pulse_req),
        .o_rdata     (pulse_rdata),
        .i_rst_hold  (rst_hold),
        .o_resetb_ext(o_resetb_ext)
    );

    readout_arbiter i_readout_arbiter (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .i_src_empty(i_src_empty),
        .i_src_hold (i_src_hold),
        .i_src_data (i_src_data),
        .o_src_read (o_src_read),
        .i_arb_ready(i_arb_ready),
        .o_arb_write(o_arb_write),
        .o_arb_data (o_arb_data)
    );

endmodule

//--- rtl/daq_pkg.sv
`include "daq_config.svh"

package daq_pkg;

    // Global bus address and data
    typedef logic [`DAQ_ABUS_WIDTH-1:0] bus_addr_t;
    typedef logic [`DAQ_DBUS_WIDTH-1:0] bus_data_t;

    // Offset relative to a block base
    typedef logic [`DAQ_LOCAL_ADD_WIDTH-1:0] local_addr_t;

    // Readout stream word
    typedef logic [`DAQ_WORD_WIDTH-1:0] arb_word_t;

    // One bit per readout source
    typedef logic [`DAQ_NUM_SOURCES-1:0] src_mask_t;

    // Per-block bus request
    // rd/wr only set inside the block's window
    typedef struct packed {
        logic        rd;
        logic        wr;
        local_addr_t add;
        bus_data_t   data;
    } ip_req_t;

    // Board control outputs
    typedef struct packed {
        logic       mgt_ref_sel;
        logic [7:0] lemo_mux;
        logic [2:0] ntc_mux;
    } board_ctrl_t;

    // Chip reset pulser FSM
    typedef enum logic [1:0] {
        IDLE,
        DELAY,
        PULSE
    } pulser_state_t;

endpackage

//--- rtl/readout_arbiter.sv
`timescale 1ns/1ps
`include "daq_config.svh"

module readout_arbiter (
    input  logic                                         BUS_CLK,
    input  logic                                         BUS_RST,
    input  daq_pkg::src_mask_t                           i_src_empty,
    input  daq_pkg::src_mask_t                           i_src_hold,
    input  daq_pkg::arb_word_t [`DAQ_NUM_SOURCES-1:0]    i_src_data,
    output daq_pkg::src_mask_t                           o_src_read,
    input  logic                                         i_arb_ready,
    output logic                                         o_arb_write,
    output daq_pkg::arb_word_t                           o_arb_data
);

    localparam int NUM_SRC = `DAQ_NUM_SOURCES;
    localparam int IDX_W   = (NUM_SRC > 1) ? $clog2(NUM_SRC) : 1;

    typedef logic [IDX_W-1:0] src_idx_t;

    // Last granted source, starts at the top so source 0 goes first
    src_idx_t last_q;
    src_idx_t grant_idx;
    logic     grant_valid;

    // Hold keeps the last source, otherwise rotate from last+1
    always_comb begin : pick_source
        src_idx_t cand;
        grant_valid = 1'b0;
        grant_idx   = last_q;
        cand        = last_q;
        if (i_arb_ready) begin
            if (i_src_hold[last_q] && !i_src_empty[last_q]) begin
                grant_valid = 1'b1;
            end else begin
                // i == NUM_SRC wraps back to the last source itself
                for (int i = 1; i <= NUM_SRC; i++) begin
                    cand = src_idx_t'((int'(last_q) + i) % NUM_SRC);
                    if (!grant_valid && !i_src_empty[cand]) begin
                        grant_valid = 1'b1;
                        grant_idx   = cand;
                    end
                end
            end
        end
    end

    // FWFT pop, one source per cycle at most
    assign o_src_read = grant_valid ? (daq_pkg::src_mask_t'(1) << grant_idx) : '0;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            last_q      <= src_idx_t'(NUM_SRC - 1);
            o_arb_write <= 1'b0;
        end else begin
            o_arb_write <= grant_valid;
            if (grant_valid) begin
                last_q <= grant_idx;
            end
        end
    end

    // Word shown by the granted source, written out one cycle later
    always_ff @(posedge BUS_CLK) begin
        if (grant_valid) begin
            o_arb_data <= i_src_data[grant_idx];
        end
    end

endmodule

//--- rtl/reset_pulser.sv
`timescale 1ns/1ps

module reset_pulser (
    input  logic               BUS_CLK,
    input  logic               BUS_RST,
    input  daq_pkg::ip_req_t   i_req,
    output daq_pkg::bus_data_t o_rdata,
    input  logic               i_rst_hold,
    output logic               o_resetb_ext
);

    // Register offsets
    localparam daq_pkg::local_addr_t ADD_START = 8'd0;
    localparam daq_pkg::local_addr_t ADD_DELAY = 8'd1;
    localparam daq_pkg::local_addr_t ADD_WIDTH = 8'd2;
    localparam daq_pkg::local_addr_t ADD_IDLE  = 8'd3;

    daq_pkg::bus_data_t     delay_q;
    daq_pkg::bus_data_t     width_q;
    daq_pkg::bus_data_t     count_q;
    daq_pkg::pulser_state_t state_q;

    // Two-flop synchronizer plus one flop for release detect
    logic [1:0] hold_ff_q;
    logic       hold_prev_q;
    logic       hold_release;
    logic       start;
    logic       idle;
    logic       pulse;

    assign idle         = (state_q == daq_pkg::IDLE);
    assign pulse        = (state_q == daq_pkg::PULSE);
    assign hold_release = hold_prev_q & ~hold_ff_q[1];
    // Software start or hold release
    assign start        = (i_req.wr && (i_req.add == ADD_START)) || hold_release;

    // Delay and width
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            delay_q <= '0;
            width_q <= 8'd1;
        end else if (i_req.wr) begin
            if (i_req.add == ADD_DELAY) delay_q <= i_req.data;
            if (i_req.add == ADD_WIDTH) width_q <= i_req.data;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (i_req.rd) begin
            case (i_req.add)
                ADD_DELAY: o_rdata <= delay_q;
                ADD_WIDTH: o_rdata <= width_q;
                ADD_IDLE:  o_rdata <= {7'b0, idle};
                default:   o_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            hold_ff_q   <= '0;
            hold_prev_q <= 1'b0;
        end else begin
            hold_ff_q   <= {hold_ff_q[0], i_rst_hold};
            hold_prev_q <= hold_ff_q[1];
        end
    end

    // Start edge T loads delay, pulse begins delay+1 edges later
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            state_q <= daq_pkg::IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                daq_pkg::IDLE: begin
                    // Busy starts are dropped since only IDLE looks at start
                    if (start) begin
                        state_q <= daq_pkg::DELAY;
                        count_q <= delay_q;
                    end
                end
                daq_pkg::DELAY: begin
                    if (count_q == '0) begin
                        // Zero width means no pulse at all
                        state_q <= (width_q == '0) ? daq_pkg::IDLE : daq_pkg::PULSE;
                        count_q <= width_q - 8'd1;
                    end else begin
                        count_q <= count_q - 8'd1;
                    end
                end
                daq_pkg::PULSE: begin
                    if (count_q == '0) begin
                        state_q <= daq_pkg::IDLE;
                    end else begin
                        count_q <= count_q - 8'd1;
                    end
                end
                default: begin
                    state_q <= daq_pkg::IDLE;
                end
            endcase
        end
    end

    // Active-low chip reset
    assign o_resetb_ext = ~(hold_ff_q[1] | pulse);

endmodule

//--- rtl/system_regs.sv
`timescale 1ns/1ps
`include "daq_config.svh"

module system_regs (
    input  logic               BUS_CLK,
    input  logic               BUS_RST,
    input  daq_pkg::ip_req_t   i_req,
    output daq_pkg::bus_data_t o_rdata
);

    // Register offsets
    localparam daq_pkg::local_addr_t ADD_VERSION    = 8'd0;
    localparam daq_pkg::local_addr_t ADD_MINOR      = 8'd1;
    localparam daq_pkg::local_addr_t ADD_MAJOR      = 8'd2;
    localparam daq_pkg::local_addr_t ADD_BOARD_ID   = 8'd3;
    localparam daq_pkg::local_addr_t ADD_CFG_READ   = 8'd4;
    localparam daq_pkg::local_addr_t ADD_CFG_WRITE  = 8'd5;

    // Set by software once the reference clock is programmed
    logic clk_configured_q;

    // Flag write
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            clk_configured_q <= 1'b0;
        end else if (i_req.wr && (i_req.add == ADD_CFG_WRITE)) begin
            clk_configured_q <= i_req.data[0];
        end
    end

    // Read byte captured on the rd edge
    always_ff @(posedge BUS_CLK) begin
        if (i_req.rd) begin
            case (i_req.add)
                ADD_VERSION: begin
                    o_rdata <= `DAQ_VERSION;
                end
                ADD_MINOR: begin
                    o_rdata <= `DAQ_VERSION_MINOR;
                end
                ADD_MAJOR: begin
                    o_rdata <= `DAQ_VERSION_MAJOR;
                end
                ADD_BOARD_ID: begin
                    o_rdata <= `DAQ_BOARD_ID;
                end
                ADD_CFG_READ: begin
                    o_rdata <= {7'b0, clk_configured_q};
                end
                // Offset 5 is write-only
                default: begin
                    o_rdata <= '0;
                end
            endcase
        end
    end

endmodule

//--- tests/daq_trace.txt
# W addr data | R addr expected | S sense | C expected board_ctrl | L cycles level
# X/H delay width | P source word hold | D words to drain, all values hex
# System block identification and configured flag
R 00000300 01
R 00000301 00
R 00000302 02
R 00000303 00
R 00000304 00
W 00000305 01
R 00000304 01
R 00000305 00
R 00000200 00
R 00000600 00
R 000103ff 00
# Board GPIO control and sense
C 800
W 00000501 5a
W 00000502 85
C 2d5
R 00000501 5a
R 00000502 85
S a
R 00000503 0a
S 5
R 00000503 05
W 00000502 03
C ad3
R 00000502 03
# Write-started chip reset pulses
X 0 1
X 3 4
# Hold then release with a programmed pulse
W 00000500 01
R 00000500 01
L 3 0
H 2 3
R 00000500 00
# Round robin without hold
P 0 a0000001 0
P 1 b0000001 0
P 2 c0000001 0
P 0 a0000002 0
P 1 b0000002 0
P 2 c0000002 0
P 0 a0000003 0
P 2 c0000003 0
P 1 b0000003 0
D 9
# Hold on source 1 drains it first
P 0 a0000010 0
P 1 b0000010 1
P 1 b0000011 1
P 1 b0000012 1
P 1 b0000013 1
P 2 c0000010 0
P 0 a0000011 0
P 2 c0000011 0
D 8

//--- tests/tb_daq_core.sv
`timescale 1ns/1ps
`include "daq_config.svh"

module tb_daq_core;

    localparam int NSRC = `DAQ_NUM_SOURCES;

    logic                                         BUS_CLK;
    logic                                         BUS_RST;
    daq_pkg::bus_addr_t                           i_bus_add;
    daq_pkg::bus_data_t                           i_bus_data;
    daq_pkg::bus_data_t                           o_bus_data;
    logic                                         i_bus_rd;
    logic                                         i_bus_wr;
    logic [3:0]                                   i_gpio_sense;
    daq_pkg::board_ctrl_t                         o_board_ctrl;
    logic                                         o_resetb_ext;
    daq_pkg::src_mask_t                           i_src_empty;
    daq_pkg::src_mask_t                           i_src_hold;
    daq_pkg::arb_word_t [`DAQ_NUM_SOURCES-1:0]    src_data;
    daq_pkg::src_mask_t                           o_src_read;
    logic                                         i_arb_ready;
    logic                                         o_arb_write;
    daq_pkg::arb_word_t                           o_arb_data;

    // FWFT source FIFO contents and hold flags
    daq_pkg::arb_word_t src_q [NSRC][$];
    daq_pkg::src_mask_t hold_mask;
    // Round-robin model pointer, source 0 goes first after reset
    int                 mdl_last = NSRC - 1;
    int                 grants;
    logic [31:0]        lfsr_state = 32'h3ceb_e295;
    string              lines[$];
    int                 cycle_cnt = 0;
    int                 cycle_limit = 0;

    daq_core i_dut (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_bus_add   (i_bus_add),
        .i_bus_data  (i_bus_data),
        .o_bus_data  (o_bus_data),
        .i_bus_rd    (i_bus_rd),
        .i_bus_wr    (i_bus_wr),
        .i_gpio_sense(i_gpio_sense),
        .o_board_ctrl(o_board_ctrl),
        .o_resetb_ext(o_resetb_ext),
        .i_src_empty (i_src_empty),
        .i_src_hold  (i_src_hold),
        .i_src_data  (src_data),
        .o_src_read  (o_src_read),
        .i_arb_ready (i_arb_ready),
        .o_arb_write (o_arb_write),
        .o_arb_data  (o_arb_data)
    );

    // 20 ns bus clock
    initial BUS_CLK = 1'b0;
    always #10 BUS_CLK = ~BUS_CLK;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    always @(posedge BUS_CLK) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("Timeout: run went past %0d cycles", cycle_limit));
        end
    end

    task automatic check_byte(input string name, input daq_pkg::bus_data_t exp,
                              input daq_pkg::bus_data_t act);
        if (act !== exp) abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input daq_pkg::arb_word_t exp,
                              input daq_pkg::arb_word_t act);
        if (act !== exp) abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_ctrl(input string name, input daq_pkg::board_ctrl_t exp,
                              input daq_pkg::board_ctrl_t act);
        if (act !== exp) abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    endtask

    // Right-shift Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    // Queue fronts onto the FWFT ports
    task automatic drive_sources();
        for (int s = 0; s < NSRC; s++) begin
            i_src_empty[s] = (src_q[s].size() == 0);
            src_data[s]    = (src_q[s].size() == 0) ? '0 : src_q[s][0];
        end
        i_src_hold = hold_mask;
    endtask

    // One clock, pop strobes taken mid-cycle, inputs updated 2 ns after the edge
    task automatic tick();
        daq_pkg::src_mask_t rd;
        logic               rdy;
        @(negedge BUS_CLK);
        rd  = o_src_read;
        rdy = i_arb_ready;
        @(posedge BUS_CLK);
        #2;
        if ($countones(rd) > 1) abort_run("Arbiter granted more than one source in one cycle");
        if (rd != '0 && !rdy) abort_run("Arbiter granted a source while ready was low");
        for (int s = 0; s < NSRC; s++) begin
            if (rd[s] && src_q[s].size() == 0) abort_run("Arbiter read an empty source");
            if (rd[s]) void'(src_q[s].pop_front());
        end
        if (rd != '0) grants++;
        drive_sources();
    endtask

    task automatic bus_write(input daq_pkg::bus_addr_t add, input daq_pkg::bus_data_t data);
        i_bus_add  = add;
        i_bus_data = data;
        i_bus_wr   = 1'b1;
        tick();
        i_bus_wr   = 1'b0;
    endtask

    // Data shows up right after the rd edge
    task automatic bus_read(input daq_pkg::bus_addr_t add, output daq_pkg::bus_data_t data);
        i_bus_add = add;
        i_bus_rd  = 1'b1;
        tick();
        i_bus_rd  = 1'b0;
        data      = o_bus_data;
    endtask

    // Start edge T is the write edge, or 3 edges after the hold release write
    task automatic pulse_test(input string name, input int dly, input int wid,
                              input logic from_hold);
        int   t0;
        logic busy;
        logic pulse;
        logic exp_level;
        t0 = from_hold ? 3 : 0;
        bus_write(`DAQ_PULSE_RST_BASEADDR + 1, dly[7:0]);
        bus_write(`DAQ_PULSE_RST_BASEADDR + 2, wid[7:0]);
        if (from_hold) bus_write(`DAQ_GPIO_BASEADDR, 8'h00);
        else bus_write(`DAQ_PULSE_RST_BASEADDR, 8'h00);
        // Poll the idle bit every cycle
        i_bus_add = `DAQ_PULSE_RST_BASEADDR + 3;
        i_bus_rd  = 1'b1;
        for (int k = 1; k <= t0 + dly + wid + 3; k++) begin
            tick();
            pulse     = (k - t0 >= dly + 1) && (k - t0 <= dly + wid);
            // Hold still in the synchronizer for one more edge
            exp_level = !(pulse || (from_hold && k < 2));
            check_level(name, exp_level, o_resetb_ext);
            if (k >= 2) begin
                busy = (k - 1 >= t0) && (k - 1 <= t0 + dly + wid);
                check_byte(name, {7'b0, !busy}, o_bus_data);
            end
        end
        i_bus_rd = 1'b0;
    endtask

    // Build expected order from the queues, then drain under random ready
    task automatic drain(input string name, input int count);
        daq_pkg::arb_word_t expect_q[$];
        int                 idx[NSRC];
        int                 pick;
        int                 cand;
        int                 writes;
        logic               ready_now;
        foreach (idx[s]) idx[s] = 0;
        for (int n = 0; n < count; n++) begin
            pick = -1;
            if (hold_mask[mdl_last] && idx[mdl_last] < src_q[mdl_last].size()) begin
                pick = mdl_last;
            end else begin
                for (int i = 1; i <= NSRC; i++) begin
                    cand = (mdl_last + i) % NSRC;
                    if (pick < 0 && idx[cand] < src_q[cand].size()) pick = cand;
                end
            end
            if (pick < 0) abort_run("Trace drains more words than the sources hold");
            expect_q.push_back(src_q[pick][idx[pick]]);
            idx[pick]++;
            mdl_last = pick;
        end
        grants = 0;
        writes = 0;
        while (writes < count) begin
            lfsr_state  = lfsr_step(lfsr_state);
            i_arb_ready = (grants < count) ? lfsr_state[0] : 1'b0;
            ready_now   = i_arb_ready;
            tick();
            // Back-pressure cycle leaves the next write low
            if (!ready_now) check_level(name, 1'b0, o_arb_write);
            if (o_arb_write) begin
                check_word(name, expect_q[writes], o_arb_data);
                writes++;
            end
        end
        i_arb_ready = 1'b0;
        tick();
        check_level(name, 1'b0, o_arb_write);
    endtask

    initial begin : run_trace
        int                  fd;
        string               text;
        string               cmd;
        string               name;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         c;
        daq_pkg::bus_data_t  rdata;
        BUS_RST      = 1'b1;
        i_bus_add    = '0;
        i_bus_data   = '0;
        i_bus_rd     = 1'b0;
        i_bus_wr     = 1'b0;
        i_gpio_sense = '0;
        i_arb_ready  = 1'b0;
        hold_mask    = '0;
        drive_sources();
        fd = $fopen("tests/daq_trace.txt", "r");
        if (fd == 0) abort_run("Could not open tests/daq_trace.txt");
        while (!$feof(fd)) begin
            if ($fgets(text, fd) > 0) lines.push_back(text);
        end
        $fclose(fd);
        cycle_limit = lines.size() * 64;
        repeat (16) tick();
        BUS_RST = 1'b0;
        tick();
        foreach (lines[i]) begin
            text = lines[i];
            if (text.len() < 2 || text.getc(0) == "#") continue;
            cmd  = text.substr(0, 0);
            name = $sformatf("trace line %0d (%s)", i + 1, cmd);
            a = '0;
            b = '0;
            c = '0;
            void'($sscanf(text.substr(2, text.len() - 1), "%h %h %h", a, b, c));
            case (cmd)
                "W": bus_write(a, b[7:0]);
                "R": begin
                    bus_read(a, rdata);
                    check_byte(name, b[7:0], rdata);
                end
                "S": i_gpio_sense = a[3:0];
                "C": check_ctrl(name, daq_pkg::board_ctrl_t'(a[11:0]), o_board_ctrl);
                "L": begin
                    repeat (a) tick();
                    check_level(name, b[0], o_resetb_ext);
                end
                "X": pulse_test(name, a, b, 1'b0);
                "H": pulse_test(name, a, b, 1'b1);
                "P": begin
                    src_q[a].push_back(b);
                    hold_mask[a] = c[0];
                    drive_sources();
                end
                "D": drain(name, a);
                default: abort_run($sformatf("Unknown command in %s", name));
            endcase
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
